// File: build.f
+incdir+include
rtl/rv_pkg.sv
rtl/instr_decoder.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/load_store_unit.sv
rtl/cpu_control.sv
rtl/rv_core.sv
verification/rv_core_tb.sv

// File: include/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// ======================================================================
// datapath widths
// ======================================================================
`define RV_XLEN       32
`define RV_REG_IDX_W  5
`define RV_SHAMT_W    5
`define RV_RESET_PC   32'h0000_0000

// base opcodes, instr[6:0]
`define RV_OP_LUI     7'b0110111
`define RV_OP_AUIPC   7'b0010111
`define RV_OP_JAL     7'b1101111
`define RV_OP_JALR    7'b1100111
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_LOAD    7'b0000011
`define RV_OP_STORE   7'b0100011
`define RV_OP_ALUI    7'b0010011
`define RV_OP_ALU     7'b0110011

`endif

// File: rtl/alu.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module alu (
    input  logic            clk_1s,
    input  logic            rst,
    input  logic            start,
    input  rv_pkg::alu_op_e op,
    input  rv_pkg::word_t   src_a,
    input  rv_pkg::word_t   src_b,
    output rv_pkg::word_t   result,
    output logic            done
);
    import rv_pkg::*;

    alu_op_e                op_q;
    logic                   busy;
    logic [`RV_SHAMT_W-1:0] count;
    logic [`RV_SHAMT_W-1:0] shamt;
    logic                   is_shift;
    word_t                  quick;
    word_t                  shifted;

    assign shamt    = src_b[`RV_SHAMT_W-1:0];
    assign is_shift = (op == ALU_SLL) || (op == ALU_SRL) || (op == ALU_SRA);

    // single-cycle operations
    always_comb begin
        case (op)
            ALU_ADD:  quick = src_a + src_b;
            ALU_SUB:  quick = src_a - src_b;
            ALU_XOR:  quick = src_a ^ src_b;
            ALU_OR:   quick = src_a | src_b;
            ALU_AND:  quick = src_a & src_b;
            ALU_SLT:  quick = word_t'($signed(src_a) < $signed(src_b));
            ALU_SLTU: quick = word_t'(src_a < src_b);
            default:  quick = src_a;
        endcase
    end

    // one bit position per step
    always_comb begin
        case (op_q)
            ALU_SLL: shifted = {result[`RV_XLEN-2:0], 1'b0};
            ALU_SRA: shifted = {result[`RV_XLEN-1], result[`RV_XLEN-1:1]};
            default: shifted = {1'b0, result[`RV_XLEN-1:1]};
        endcase
    end

    always_ff @(posedge clk_1s) begin
        if (rst) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                op_q   <= op;
                count  <= shamt;
                result <= is_shift ? src_a : quick;
                busy   <= is_shift && (shamt != '0);
                done   <= !is_shift || (shamt == '0);
            end else if (busy) begin
                result <= shifted;
                count  <= count - 1'b1;
                if (count == 1) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

endmodule

// File: rtl/cpu_control.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module cpu_control (
    input  logic                 clk_1s,
    input  logic                 rst,
    output rv_pkg::word_t        instr,
    input  rv_pkg::instr_group_e group,
    input  logic [2:0]           funct3,
    input  logic                 alt,
    input  rv_pkg::word_t        imm,
    input  rv_pkg::word_t        rs1_data,
    input  rv_pkg::word_t        rs2_data,
    output logic                 rd_wen,
    output rv_pkg::word_t        rd_data,
    output rv_pkg::alu_op_e      alu_op,
    output rv_pkg::word_t        alu_a,
    output rv_pkg::word_t        alu_b,
    output logic                 alu_start,
    input  rv_pkg::word_t        alu_result,
    input  logic                 alu_done,
    input  rv_pkg::bus_len_e     store_len,
    input  rv_pkg::word_t        store_data,
    input  rv_pkg::word_t        load_data,
    output rv_pkg::word_t        bus_address,
    output rv_pkg::word_t        bus_wdata,
    output rv_pkg::bus_len_e     bus_len,
    output logic                 bus_en,
    input  logic                 bus_ready,
    input  rv_pkg::word_t        bus_rdata
);
    import rv_pkg::*;

    ctrl_state_e state;
    word_t       pc;
    word_t       next_pc;
    word_t       pc_plus4;
    word_t       mem_addr;
    word_t       operand;
    alu_op_e     op_sel;
    logic        is_shift;
    logic        take_branch;

    assign pc_plus4 = pc + 32'd4;
    assign mem_addr = rs1_data + imm;
    assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);
    assign operand  = (group == GRP_ALU) ? rs2_data : imm;

    always_comb begin
        case (funct3)
            3'b000:  op_sel = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op_sel = ALU_SLL;
            3'b010:  op_sel = ALU_SLT;
            3'b011:  op_sel = ALU_SLTU;
            3'b100:  op_sel = ALU_XOR;
            3'b101:  op_sel = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op_sel = ALU_OR;
            default: op_sel = ALU_AND;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  take_branch = (rs1_data == rs2_data);
            3'b001:  take_branch = (rs1_data != rs2_data);
            3'b100:  take_branch = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  take_branch = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  take_branch = (rs1_data < rs2_data);
            3'b111:  take_branch = (rs1_data >= rs2_data);
            default: take_branch = 1'b0;
        endcase
    end

    // ==================================================================
    // instruction sequencing
    // ==================================================================
    always_ff @(posedge clk_1s) begin
        if (rst) begin
            state     <= ST_FETCH;
            pc        <= `RV_RESET_PC;
            bus_en    <= 1'b0;
            rd_wen    <= 1'b0;
            alu_start <= 1'b0;
        end else begin
            bus_en    <= 1'b0;
            rd_wen    <= 1'b0;
            alu_start <= 1'b0;
            case (state)
                ST_FETCH: begin
                    bus_address <= pc;
                    bus_len     <= BUS_READ32;
                    bus_en      <= 1'b1;
                    state       <= ST_FETCH_WAIT;
                end
                ST_FETCH_WAIT: begin
                    if (bus_ready) begin
                        instr <= bus_rdata;
                        state <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    next_pc <= pc_plus4;
                    case (group)
                        GRP_LUI, GRP_AUIPC: begin
                            rd_data <= (group == GRP_LUI) ? imm : pc + imm;
                            rd_wen  <= 1'b1;
                            state   <= ST_WRITE;
                        end
                        GRP_JAL, GRP_JALR: begin
                            rd_data <= pc_plus4;
                            rd_wen  <= 1'b1;
                            // jalr target drops bit 0
                            next_pc <= (group == GRP_JAL) ? pc + imm
                                                          : {mem_addr[`RV_XLEN-1:1], 1'b0};
                            state   <= ST_WRITE;
                        end
                        GRP_BRANCH: begin
                            if (take_branch) begin
                                next_pc <= pc + imm;
                            end
                            state <= ST_PC;
                        end
                        GRP_LOAD, GRP_STORE: begin
                            bus_address <= mem_addr;
                            bus_len     <= (group == GRP_LOAD) ? BUS_READ32 : store_len;
                            bus_wdata   <= store_data;
                            bus_en      <= 1'b1;
                            state       <= ST_MEM;
                        end
                        GRP_ALU, GRP_ALUI: begin
                            alu_a     <= rs1_data;
                            alu_b     <= is_shift ? word_t'(operand[`RV_SHAMT_W-1:0]) : operand;
                            alu_op    <= op_sel;
                            alu_start <= 1'b1;
                            state     <= ST_ALU;
                        end
                        default: begin
                            state <= ST_PC;
                        end
                    endcase
                end
                ST_MEM: begin
                    if (bus_ready) begin
                        if (group == GRP_LOAD) begin
                            rd_data <= load_data;
                            rd_wen  <= 1'b1;
                            state   <= ST_WRITE;
                        end else begin
                            state <= ST_PC;
                        end
                    end
                end
                ST_ALU: begin
                    if (alu_done) begin
                        rd_data <= alu_result;
                        rd_wen  <= 1'b1;
                        state   <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    state <= ST_PC;
                end
                ST_PC: begin
                    pc    <= next_pc;
                    state <= ST_FETCH;
                end
                default: begin
                    state <= ST_FETCH;
                end
            endcase
        end
    end

endmodule

// File: rtl/instr_decoder.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module instr_decoder (
    input  rv_pkg::word_t        instr,
    output rv_pkg::instr_group_e group,
    output logic [2:0]           funct3,
    output logic                 alt,
    output rv_pkg::reg_idx_t     rs1_idx,
    output rv_pkg::reg_idx_t     rs2_idx,
    output rv_pkg::reg_idx_t     rd_idx,
    output rv_pkg::word_t        imm
);
    import rv_pkg::*;

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    assign funct3  = instr[14:12];
    assign rs1_idx = instr[19:15];
    assign rs2_idx = instr[24:20];
    assign rd_idx  = instr[11:7];

    // ==================================================================
    // immediate formats
    // ==================================================================
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        case (instr[6:0])
            `RV_OP_LUI:    group = GRP_LUI;
            `RV_OP_AUIPC:  group = GRP_AUIPC;
            `RV_OP_JAL:    group = GRP_JAL;
            `RV_OP_JALR:   group = GRP_JALR;
            `RV_OP_BRANCH: group = GRP_BRANCH;
            `RV_OP_LOAD:   group = GRP_LOAD;
            `RV_OP_STORE:  group = GRP_STORE;
            `RV_OP_ALUI:   group = GRP_ALUI;
            `RV_OP_ALU:    group = GRP_ALU;
            // fence, system and unknown words
            default:       group = GRP_NOP;
        endcase
    end

    always_comb begin
        case (group)
            GRP_LUI, GRP_AUIPC:           imm = imm_u;
            GRP_JAL:                      imm = imm_j;
            GRP_BRANCH:                   imm = imm_b;
            GRP_STORE:                    imm = imm_s;
            GRP_JALR, GRP_LOAD, GRP_ALUI: imm = imm_i;
            default:                      imm = '0;
        endcase
    end

    // sub/sra select, only srai among the immediate forms
    always_comb begin
        if (group == GRP_ALU) begin
            alt = instr[30];
        end else if (group == GRP_ALUI && funct3 == 3'b101) begin
            alt = instr[30];
        end else begin
            alt = 1'b0;
        end
    end

endmodule

// File: rtl/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit (
    input  logic [2:0]       funct3,
    input  rv_pkg::word_t    rs2_data,
    input  rv_pkg::word_t    bus_rdata,
    output rv_pkg::bus_len_e store_len,
    output rv_pkg::word_t    store_data,
    output rv_pkg::word_t    load_data
);
    import rv_pkg::*;

    // ==================================================================
    // store side
    // ==================================================================
    always_comb begin
        case (funct3[1:0])
            2'b00: begin
                store_len  = BUS_WRITE8;
                store_data = {24'b0, rs2_data[7:0]};
            end
            2'b01: begin
                store_len  = BUS_WRITE16;
                store_data = {16'b0, rs2_data[15:0]};
            end
            default: begin
                store_len  = BUS_WRITE32;
                store_data = rs2_data;
            end
        endcase
    end

    // ==================================================================
    // load side, byte at the address sits in the low lane
    // ==================================================================
    always_comb begin
        case (funct3)
            3'b000:  load_data = {{24{bus_rdata[7]}}, bus_rdata[7:0]};
            3'b001:  load_data = {{16{bus_rdata[15]}}, bus_rdata[15:0]};
            3'b100:  load_data = {24'b0, bus_rdata[7:0]};
            3'b101:  load_data = {16'b0, bus_rdata[15:0]};
            default: load_data = bus_rdata;
        endcase
    end

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic             clk_1s,
    input  logic             rst,
    input  rv_pkg::reg_idx_t rs1_idx,
    input  rv_pkg::reg_idx_t rs2_idx,
    input  rv_pkg::reg_idx_t rd_idx,
    input  logic             rd_wen,
    input  rv_pkg::word_t    rd_data,
    output rv_pkg::word_t    rs1_data,
    output rv_pkg::word_t    rs2_data
);
    import rv_pkg::*;

    // x1..x31, x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk_1s) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wen && rd_idx != '0) begin
            regs[rd_idx] <= rd_data;
        end
    end

    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

// File: rtl/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic             clk_1s,
    input  logic             rst,
    output rv_pkg::word_t    bus_address,
    output rv_pkg::word_t    bus_wdata,
    output rv_pkg::bus_len_e bus_len,
    output logic             bus_en,
    input  logic             bus_ready,
    input  rv_pkg::word_t    bus_rdata
);
    import rv_pkg::*;

    // decoder
    word_t        instr;
    instr_group_e group;
    logic [2:0]   funct3;
    logic         alt;
    word_t        imm;
    reg_idx_t     rs1_idx;
    reg_idx_t     rs2_idx;
    reg_idx_t     rd_idx;

    // register file
    word_t rs1_data;
    word_t rs2_data;
    logic  rd_wen;
    word_t rd_data;

    // alu
    alu_op_e alu_op;
    word_t   alu_a;
    word_t   alu_b;
    logic    alu_start;
    word_t   alu_result;
    logic    alu_done;

    // load/store lanes
    bus_len_e store_len;
    word_t    store_data;
    word_t    load_data;

    cpu_control control_inst (.*);

    instr_decoder decoder_inst (.*);

    reg_file reg_file_inst (.*);

    alu alu_inst (
        .clk_1s (clk_1s),
        .rst    (rst),
        .start  (alu_start),
        .op     (alu_op),
        .src_a  (alu_a),
        .src_b  (alu_b),
        .result (alu_result),
        .done   (alu_done)
    );

    load_store_unit lsu_inst (.*);

endmodule

// File: rtl/rv_pkg.sv
`include "rv_params.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]      word_t;
    typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;

    // decoded instruction class
    typedef enum logic [3:0] {
        GRP_LUI,
        GRP_AUIPC,
        GRP_JAL,
        GRP_JALR,
        GRP_BRANCH,
        GRP_LOAD,
        GRP_STORE,
        GRP_ALUI,
        GRP_ALU,
        GRP_NOP
    } instr_group_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    typedef enum logic [1:0] {
        BUS_READ32,
        BUS_WRITE8,
        BUS_WRITE16,
        BUS_WRITE32
    } bus_len_e;

    // sequencing states of cpu_control
    typedef enum logic [2:0] {
        ST_FETCH,
        ST_FETCH_WAIT,
        ST_EXEC,
        ST_MEM,
        ST_ALU,
        ST_WRITE,
        ST_PC
    } ctrl_state_e;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it
cd "$(dirname "$0")" &&
verilator --binary --timing -f build.f --top-module rv_core_tb -o rv_core_sim &&
./obj_dir/rv_core_sim || exit 1

// File: verification/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_core_tb;
    import rv_pkg::*;

    localparam int MAX_ROWS    = 64;
    localparam int ROW_WORDS   = 12;
    localparam int RESULT_ADDR = 32'h200;
    localparam int DATA_ADDR   = 32'h80;
    localparam logic [31:0] DATA_WORD = 32'h8765_43A1;

    logic     clk_1s;
    logic     rst;
    word_t    bus_address;
    word_t    bus_wdata;
    bus_len_e bus_len;
    logic     bus_en;
    logic     bus_ready;
    word_t    bus_rdata;

    word_t    mem [0:255];
    word_t    prog [MAX_ROWS][ROW_WORDS];
    int       prog_len [MAX_ROWS];
    bus_len_e exp_len [MAX_ROWS];
    word_t    exp_data [MAX_ROWS];
    int       num_rows;
    int       cycles;
    int       cycle_limit = MAX_ROWS * ROW_WORDS * 60;

    // memory side state
    int       wait_cnt;
    word_t    req_addr;
    word_t    req_wdata;
    bus_len_e req_len;
    logic     first_pending;
    logic     result_seen;
    bus_len_e res_len;
    word_t    res_data;

    rv_core rv_core_inst (.*);

    always #20 clk_1s = ~clk_1s;

    // ======================================================================
    // instruction encoders
    // ======================================================================
    function automatic word_t rtype(input int f7, input int rs2, input int rs1,
                                    input int f3, input int rd);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), `RV_OP_ALU};
    endfunction

    function automatic word_t itype(input int imm, input int rs1, input int f3,
                                    input int rd, input logic [6:0] op);
        logic [31:0] v;
        v = imm;
        return {v[11:0], 5'(rs1), 3'(f3), 5'(rd), op};
    endfunction

    function automatic word_t stype(input int imm, input int rs2, input int rs1, input int f3);
        logic [31:0] v;
        v = imm;
        return {v[11:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:0], `RV_OP_STORE};
    endfunction

    function automatic word_t btype(input int imm, input int rs2, input int rs1, input int f3);
        logic [31:0] v;
        v = imm;
        return {v[12], v[10:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:1], v[11], `RV_OP_BRANCH};
    endfunction

    function automatic word_t jtype(input int imm, input int rd);
        logic [31:0] v;
        v = imm;
        return {v[20], v[10:1], v[11], v[19:12], 5'(rd), `RV_OP_JAL};
    endfunction

    // ======================================================================
    // stimulus table
    // ======================================================================
    task automatic add_instr(input word_t w);
        prog[num_rows][prog_len[num_rows]] = w;
        prog_len[num_rows]++;
    endtask

    // x1 = -8, x2 = 15, x5 = 1, x9 = 31 in every row
    task automatic start_row();
        prog_len[num_rows] = 0;
        add_instr(itype(-8, 0, 0, 1, `RV_OP_ALUI));
        add_instr(itype(15, 0, 0, 2, `RV_OP_ALUI));
        add_instr(itype(1, 0, 0, 5, `RV_OP_ALUI));
        add_instr(itype(31, 0, 0, 9, `RV_OP_ALUI));
    endtask

    task automatic finish_row(input int src, input int f3, input bus_len_e len, input word_t d);
        add_instr(stype(RESULT_ADDR, src, 0, f3));
        add_instr(jtype(0, 0));
        exp_len[num_rows]  = len;
        exp_data[num_rows] = d;
        num_rows++;
    endtask

    task automatic one_op_row(input word_t w, input word_t d);
        start_row();
        add_instr(w);
        finish_row(4, 3'b010, BUS_WRITE32, d);
    endtask

    // marker 0x11 when taken, 0x22 when not
    task automatic branch_row(input int f3, input int rs1, input int rs2, input logic taken);
        start_row();
        add_instr(itype(32'h11, 0, 0, 6, `RV_OP_ALUI));
        add_instr(btype(8, rs2, rs1, f3));
        add_instr(itype(32'h22, 0, 0, 6, `RV_OP_ALUI));
        finish_row(6, 3'b010, BUS_WRITE32, taken ? 32'h11 : 32'h22);
    endtask

    task automatic build_table();
        num_rows = 0;
        one_op_row(rtype(0, 2, 1, 0, 4), 32'h0000_0007);
        one_op_row(rtype(32, 2, 1, 0, 4), 32'hFFFF_FFE9);
        one_op_row(rtype(0, 2, 1, 4, 4), 32'hFFFF_FFF7);
        one_op_row(rtype(0, 2, 1, 6, 4), 32'hFFFF_FFFF);
        one_op_row(rtype(0, 2, 1, 7, 4), 32'h0000_0008);
        one_op_row(rtype(0, 2, 1, 2, 4), 32'h0000_0001);
        one_op_row(rtype(0, 2, 1, 3, 4), 32'h0000_0000);
        one_op_row(rtype(0, 0, 1, 1, 4), 32'hFFFF_FFF8);
        one_op_row(rtype(0, 5, 1, 1, 4), 32'hFFFF_FFF0);
        one_op_row(rtype(0, 9, 2, 1, 4), 32'h8000_0000);
        one_op_row(rtype(0, 5, 1, 5, 4), 32'h7FFF_FFFC);
        one_op_row(rtype(0, 9, 1, 5, 4), 32'h0000_0001);
        one_op_row(rtype(32, 0, 1, 5, 4), 32'hFFFF_FFF8);
        one_op_row(rtype(32, 9, 1, 5, 4), 32'hFFFF_FFFF);
        one_op_row(itype(-1, 1, 0, 4, `RV_OP_ALUI), 32'hFFFF_FFF7);
        one_op_row(itype(-7, 1, 2, 4, `RV_OP_ALUI), 32'h0000_0001);
        one_op_row(itype(-1, 1, 4, 4, `RV_OP_ALUI), 32'h0000_0007);
        one_op_row(itype(31, 1, 1, 4, `RV_OP_ALUI), 32'h0000_0000);
        one_op_row(itype(1, 1, 5, 4, `RV_OP_ALUI), 32'h7FFF_FFFC);
        one_op_row(itype(32'h401, 1, 5, 4, `RV_OP_ALUI), 32'hFFFF_FFFC);
        // loads of the preloaded word
        one_op_row(itype(DATA_ADDR, 0, 0, 4, `RV_OP_LOAD), 32'hFFFF_FFA1);
        one_op_row(itype(DATA_ADDR + 1, 0, 0, 4, `RV_OP_LOAD), 32'h0000_0043);
        one_op_row(itype(DATA_ADDR, 0, 4, 4, `RV_OP_LOAD), 32'h0000_00A1);
        one_op_row(itype(DATA_ADDR + 2, 0, 1, 4, `RV_OP_LOAD), 32'hFFFF_8765);
        one_op_row(itype(DATA_ADDR + 2, 0, 5, 4, `RV_OP_LOAD), 32'h0000_8765);
        one_op_row(itype(DATA_ADDR, 0, 2, 4, `RV_OP_LOAD), 32'h8765_43A1);
        // store widths
        start_row();
        finish_row(1, 3'b000, BUS_WRITE8, 32'h0000_00F8);
        start_row();
        finish_row(1, 3'b001, BUS_WRITE16, 32'h0000_FFF8);
        start_row();
        finish_row(1, 3'b010, BUS_WRITE32, 32'hFFFF_FFF8);
        branch_row(0, 1, 1, 1'b1);
        branch_row(0, 1, 2, 1'b0);
        branch_row(1, 1, 2, 1'b1);
        branch_row(1, 1, 1, 1'b0);
        branch_row(4, 1, 2, 1'b1);
        branch_row(4, 2, 1, 1'b0);
        branch_row(5, 2, 1, 1'b1);
        branch_row(5, 1, 2, 1'b0);
        branch_row(6, 2, 1, 1'b1);
        branch_row(6, 1, 2, 1'b0);
        branch_row(7, 1, 2, 1'b1);
        branch_row(7, 2, 1, 1'b0);
        // jal at pc 16 skips one word
        start_row();
        add_instr(jtype(8, 7));
        add_instr(itype(0, 0, 0, 7, `RV_OP_ALUI));
        finish_row(7, 3'b010, BUS_WRITE32, 32'd20);
        // jalr at pc 20 to 29 lands on 28
        start_row();
        add_instr(itype(29, 0, 0, 8, `RV_OP_ALUI));
        add_instr(itype(0, 8, 0, 7, `RV_OP_JALR));
        add_instr(itype(32'h55, 0, 0, 7, `RV_OP_ALUI));
        finish_row(7, 3'b010, BUS_WRITE32, 32'd24);
        one_op_row({20'hABCDE, 5'd4, `RV_OP_LUI}, 32'hABCD_E000);
        one_op_row({20'h00001, 5'd4, `RV_OP_AUIPC}, 32'h0000_1010);
        start_row();
        add_instr(itype(5, 0, 0, 0, `RV_OP_ALUI));
        finish_row(0, 3'b010, BUS_WRITE32, 32'h0);
        start_row();
        add_instr(itype(9, 0, 0, 4, `RV_OP_ALUI));
        add_instr(32'hFFFF_FFFF);
        add_instr(32'h0000_000F);
        add_instr(itype(1, 4, 0, 4, `RV_OP_ALUI));
        finish_row(4, 3'b010, BUS_WRITE32, 32'd10);
    endtask

    // ======================================================================
    // checks and memory model
    // ======================================================================
    task automatic check_word(input string name, input word_t expected, input word_t actual);
        assert (expected === actual) else begin
            $display("** Error at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    function automatic logic [7:0] byte_at(input word_t a);
        return 8'(mem[a[9:2]] >> (8 * a[1:0]));
    endfunction

    function automatic word_t read_aligned(input word_t a);
        return {byte_at(a + 3), byte_at(a + 2), byte_at(a + 1), byte_at(a)};
    endfunction

    task automatic write_lanes(input word_t a, input word_t d, input bus_len_e len);
        int   n;
        word_t b;
        n = (len == BUS_WRITE8) ? 1 : (len == BUS_WRITE16) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            b = a + i;
            mem[b[9:2]][8 * b[1:0] +: 8] = d[8 * i +: 8];
        end
    endtask

    always @(posedge clk_1s) begin
        #1;
        if (rst) begin
            check_word("bus_en", 32'(1'b0), 32'(bus_en));
            wait_cnt      = 0;
            first_pending = 1'b1;
            #1;
            bus_ready = 1'b0;
        end else if (wait_cnt > 0) begin
            wait_cnt--;
            #1;
            bus_ready = (wait_cnt == 0);
            if (wait_cnt == 0 && req_len == BUS_READ32) begin
                bus_rdata = read_aligned(req_addr);
            end else if (wait_cnt == 0) begin
                write_lanes(req_addr, req_wdata, req_len);
            end
        end else begin
            if (bus_en) begin
                if (first_pending) begin
                    check_word("bus_len", 32'(BUS_READ32), 32'(bus_len));
                    check_word("bus_address", `RV_RESET_PC, bus_address);
                    first_pending = 1'b0;
                end
                req_addr  = bus_address;
                req_wdata = bus_wdata;
                req_len   = bus_len;
                wait_cnt  = 1 + ($urandom % 4);
                if (bus_len != BUS_READ32 && bus_address == RESULT_ADDR) begin
                    res_len     = bus_len;
                    res_data    = bus_wdata;
                    result_seen = 1'b1;
                end
            end
            #1;
            bus_ready = 1'b0;
        end
    end

    always @(posedge clk_1s) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout, the core stopped storing results");
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

    initial begin
        word_t mask;
        void'($urandom(32'h5f243b81));
        clk_1s      = 1'b0;
        rst         = 1'b1;
        bus_ready   = 1'b0;
        bus_rdata   = '0;
        cycles      = 0;
        result_seen = 1'b0;
        build_table();
        cycle_limit = num_rows * ROW_WORDS * 60;
        for (int r = 0; r < num_rows; r++) begin
            @(posedge clk_1s);
            #2;
            rst         = 1'b1;
            result_seen = 1'b0;
            for (int i = 0; i < 256; i++) begin
                mem[i] = {16'hC0DE, 16'(i)} ^ 32'(i << 20);
            end
            for (int i = 0; i < prog_len[r]; i++) begin
                mem[i] = prog[r][i];
            end
            mem[DATA_ADDR / 4] = DATA_WORD;
            repeat (10) @(posedge clk_1s);
            #2;
            rst = 1'b0;
            wait (result_seen);
            mask = (exp_len[r] == BUS_WRITE8) ? 32'hFF :
                   (exp_len[r] == BUS_WRITE16) ? 32'hFFFF : 32'hFFFF_FFFF;
            check_word("bus_len", 32'(exp_len[r]), 32'(res_len));
            check_word("bus_wdata", exp_data[r] & mask, res_data & mask);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
